// File: src/spi_bridge_pkg.sv
// Shared types and constants for the SPI register bridge.
// Frames carry an opcode, an address and a data byte. The parser turns
// them into spi_cmd_t entries that travel through the command FIFO to
// the register-bank executor. Modules that need these definitions pull
// them in with a wildcard import in their header.

package spi_bridge_pkg;

    // Opcode bit 0 picks the access direction
    typedef enum logic {
        op_write = 1'b0,                 // Store data byte at address
        op_read  = 1'b1                  // Load address into last_read
    } spi_op_e;

    // One decoded frame, as queued for the executor
    typedef struct packed {
        spi_op_e    op;                  // Access direction
        logic [7:0] addr;                // Register address
        logic [7:0] data;                // Write data, unused for reads
    } spi_cmd_t;

    // Opcode, address, data
    localparam int unsigned FRAME_BYTES = 3;

    // Returned by reads past the end of the bank
    localparam logic [7:0] READ_MISS_BYTE = 8'hFF;

endpackage

// File: src/spi_byte.sv
// SPI mode 0 byte shifter with a crossing into the system clock.
// MOSI is sampled on SCLK rising and MISO changes on SCLK falling, MSB
// first. Chip select high acts as the asynchronous reset of the SCLK
// side. Each completed byte raises byte_valid for one clk cycle, 2 to 3
// cycles after the eighth SCLK rise. tx_byte must hold for the whole byte.

`timescale 1ns/1ps

module spi_byte (
    input  logic       clk,
    input  logic       reset,
    input  logic       spi_cs_n,     // Also clears the SCLK-side state
    input  logic       spi_sclk,     // Idle low, at most clk/4
    input  logic       spi_mosi,
    input  logic [7:0] tx_byte,      // Byte shifted out on MISO
    output logic       spi_miso,
    output logic [7:0] rx_byte,      // Last complete byte, held until next one
    output logic       byte_valid    // One clk cycle per received byte
);

    logic [6:0] shift_q;             // First seven bits of the current byte
    logic [2:0] bit_index;           // MISO bit, steps on SCLK falling
    logic       done;                // High from 8th rise to next rise
    logic       done_meta;           // First synchronizer stage
    logic       done_sync;           // Second synchronizer stage
    logic       done_prev;           // For the rising-edge detect

    // Receive side, SCLK rising
    always_ff @(posedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            shift_q <= '0;
            done    <= 1'b0;
        end else begin
            shift_q <= {shift_q[5:0], spi_mosi};
            done    <= (bit_index == 3'd0);   // Eighth bit arriving now
        end
    end

    // Whole byte is captured on the eighth rise and held for a full byte,
    // so the clk side has plenty of time to read it
    always_ff @(posedge spi_sclk) begin
        if (bit_index == 3'd0) begin
            rx_byte <= {shift_q, spi_mosi};
        end
    end

    // Transmit side, SCLK falling
    always_ff @(negedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            bit_index <= 3'd7;                // MSB out first
        end else begin
            bit_index <= bit_index - 3'd1;    // Wraps to 7 for the next byte
        end
    end

    assign spi_miso = tx_byte[bit_index];

    // Done flag into clk: two flops, then a registered edge detect
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_meta  <= 1'b0;
            done_sync  <= 1'b0;
            done_prev  <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            done_meta  <= done;
            done_sync  <= done_meta;
            done_prev  <= done_sync;
            byte_valid <= done_sync & ~done_prev;   // Single-cycle pulse
        end
    end

endmodule

// File: src/spi_frame_parser.sv
// Frame parser between the byte receiver and the command FIFO.
// Counts bytes within a chip-select frame, keeps opcode and address,
// and pushes a command one cycle after the third byte. A chip-select rise
// seen through two clk flops drops any partial frame. The byte sent back
// is last_read during the opcode byte and zero afterwards.

`timescale 1ns/1ps

module spi_frame_parser
    import spi_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       spi_cs_n,
    input  logic [7:0] rx_byte,
    input  logic       byte_valid,
    input  logic [7:0] last_read,    // Result of the latest read
    output logic [7:0] tx_byte,
    output logic       push,         // One-cycle strobe
    output spi_cmd_t   push_cmd
);

    localparam int unsigned CNT_W = $clog2(FRAME_BYTES + 1);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(FRAME_BYTES - 1);

    logic             cs_meta;       // Chip select into clk
    logic             cs_sync;
    logic [CNT_W-1:0] byte_cnt;      // Position within the frame
    spi_op_e          op_q;          // Opcode from byte 0
    logic [7:0]       addr_q;        // Address from byte 1

    // Chip select idles high, so reset leaves it high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cs_meta <= 1'b1;
            cs_sync <= 1'b1;
        end else begin
            cs_meta <= spi_cs_n;
            cs_sync <= cs_meta;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            byte_cnt <= '0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            // A byte that lands with the chip-select rise was complete,
            // so it wins. The held cs level clears the count next cycle
            if (byte_valid) begin
                if (byte_cnt == LAST_BYTE) begin
                    byte_cnt <= '0;
                    push     <= 1'b1;             // Full frame
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end else if (cs_sync) begin
                byte_cnt <= '0;                   // Drop partial frame
            end
        end
    end

    // Frame contents
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            if (byte_cnt == '0) begin
                op_q <= spi_op_e'(rx_byte[0]);
            end else if (byte_cnt == CNT_W'(1)) begin
                addr_q <= rx_byte;
            end else if (byte_cnt == LAST_BYTE) begin
                push_cmd.op   <= op_q;
                push_cmd.addr <= addr_q;
                push_cmd.data <= rx_byte;         // Ignored for reads
            end
        end
    end

    // Count only moves on byte_valid, after the byte's MSB has gone out
    assign tx_byte = (byte_cnt == '0) ? last_read : 8'h00;

    a_cnt_in_frame: assert property (
        @(posedge clk) disable iff (reset)
        byte_cnt < FRAME_BYTES
    ) else $error("byte count left the frame");

endmodule

// File: src/cmd_fifo.sv
// Command FIFO between the frame parser and the register executor.
// Circular buffer with separate read and write pointers and an occupancy
// count. The head entry is shown on pop_cmd whenever empty is low, and a
// push becomes visible the cycle after it. There is no full output since
// the SPI rate keeps the executor ahead of the parser.

`timescale 1ns/1ps

module cmd_fifo
    import spi_bridge_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  spi_cmd_t push_cmd,
    input  logic     pop,
    output spi_cmd_t pop_cmd,
    output logic     empty
);

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);

    spi_cmd_t         mem [FIFO_DEPTH];   // Entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;              // Entries held
    logic             full;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign pop_cmd = mem[rd_ptr];         // Head entry

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    // Pointers wrap at FIFO_DEPTH, which need not be a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Idle or both at once
            endcase
        end
    end

    // SPI rate bound and one-per-cycle drain keep this from firing
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        push |-> !full
    ) else $error("push into full command FIFO");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> !empty
    ) else $error("pop from empty command FIFO");

endmodule

// File: src/reg_bank_exec.sv
// Register-bank executor, the consumer side of the command FIFO.
// Pops one command in every cycle the FIFO is not empty and executes it in
// that same cycle. Writes in range update the bank, writes past it are
// dropped. Reads load last_read on the edge closing the pop cycle, with
// READ_MISS_BYTE for addresses past the bank. Reset clears bank and result.

`timescale 1ns/1ps

module reg_bank_exec
    import spi_bridge_pkg::*;
#(
    parameter int unsigned BANK_WORDS = 64
) (
    input  logic       clk,
    input  logic       reset,
    input  spi_cmd_t   pop_cmd,      // FIFO head, valid while empty is low
    input  logic       empty,
    output logic       pop,
    output logic [7:0] last_read     // Held until the next read
);

    localparam int unsigned IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

    logic [7:0]       bank [BANK_WORDS];   // The register bank
    logic             in_range;            // Address hits the bank
    logic [IDX_W-1:0] idx;
    logic [7:0]       read_value;

    assign pop = !empty;                   // Drain one per cycle

    assign in_range   = (int'(pop_cmd.addr) < BANK_WORDS);
    assign idx        = pop_cmd.addr[IDX_W-1:0];
    assign read_value = in_range ? bank[idx] : READ_MISS_BYTE;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < BANK_WORDS; i++) begin
                bank[i] <= 8'h00;
            end
            last_read <= 8'h00;
        end else if (pop) begin
            if (pop_cmd.op == op_read) begin
                last_read <= read_value;
            end else if (in_range) begin
                bank[idx] <= pop_cmd.data;   // Out of range writes vanish
            end
        end
    end

    // Head entry must hold a written command whenever it is taken
    a_pop_valid: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> !empty && !$isunknown(pop_cmd)
    ) else $error("executor popped an empty or unwritten entry");

endmodule

// File: src/spi_bridge_top.sv
// Top level of the SPI register bridge.
// The byte receiver feeds the frame parser, which queues commands in the
// FIFO for the register executor. The executor's last read result goes
// back to the parser for the opcode phase of the next frame.
// FIFO_DEPTH and BANK_WORDS are set here and passed down.

`timescale 1ns/1ps

module spi_bridge_top
    import spi_bridge_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4,
    parameter int unsigned BANK_WORDS = 64
) (
    input  logic clk,
    input  logic reset,
    input  logic spi_cs_n,
    input  logic spi_sclk,
    input  logic spi_mosi,
    output logic spi_miso
);

    logic [7:0] rx_byte;       // Receiver to parser
    logic       byte_valid;
    logic [7:0] tx_byte;       // Parser back to receiver
    logic       push;          // Parser to FIFO
    spi_cmd_t   push_cmd;
    logic       pop;           // FIFO to executor
    spi_cmd_t   pop_cmd;
    logic       empty;
    logic [7:0] last_read;     // Executor back to parser

    spi_byte u_byte (
        .clk        (clk),
        .reset      (reset),
        .spi_cs_n   (spi_cs_n),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .tx_byte    (tx_byte),
        .spi_miso   (spi_miso),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid)
    );

    spi_frame_parser u_parser (
        .clk        (clk),
        .reset      (reset),
        .spi_cs_n   (spi_cs_n),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid),
        .last_read  (last_read),
        .tx_byte    (tx_byte),
        .push       (push),
        .push_cmd   (push_cmd)
    );

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_cmd   (push_cmd),
        .pop        (pop),
        .pop_cmd    (pop_cmd),
        .empty      (empty)
    );

    reg_bank_exec #(
        .BANK_WORDS (BANK_WORDS)
    ) u_exec (
        .clk        (clk),
        .reset      (reset),
        .pop_cmd    (pop_cmd),
        .empty      (empty),
        .pop        (pop),
        .last_read  (last_read)
    );

endmodule

// File: dv/spi_bridge_checker.sv
// Bus monitor for the SPI register bridge testbench.
// MISO is sampled on SCLK rising, MSB first, and assembled into bytes.
// The first byte of a frame must match the reply latched on the frame
// strobe, the address and data bytes must be zero. Frames that open too
// soon after chip select rose are reported as well. The counts go back
// to the testbench top for its closing line.

`timescale 1ns/1ps

module spi_bridge_checker #(
    parameter int MIN_GAP_CYCLES = 16
) (
    input  logic       clk,
    input  logic       spi_cs_n,
    input  logic       spi_sclk,
    input  logic       spi_miso,
    input  logic       frame_strobe,     // Marks exp_reply for the next frame
    input  logic [7:0] exp_reply,        // Opcode-phase byte of that frame
    output int         mismatch_count,
    output int         gap_errors,
    output int         bytes_checked
);

    logic [7:0] expected_q = 8'h00;      // Reply for the current frame
    int         gap_cycles = MIN_GAP_CYCLES;   // Bus counts as idle at start
    int         mismatch_q = 0;
    int         gap_q      = 0;
    int         bytes_q    = 0;
    int         frame_idx  = 0;          // Frames numbered from 1
    int         bit_cnt    = 0;
    int         byte_pos   = 0;          // 0 opcode, 1 address, 2 data
    logic [7:0] shift      = 8'h00;
    logic [7:0] want;

    assign mismatch_count = mismatch_q;
    assign gap_errors     = gap_q;
    assign bytes_checked  = bytes_q;

    // Reply capture and chip-select gap count in clk cycles
    always @(posedge clk) begin
        if (frame_strobe) begin
            expected_q <= exp_reply;
        end
        if (spi_cs_n) begin
            gap_cycles <= gap_cycles + 1;
        end else begin
            gap_cycles <= 0;
        end
    end

    // SCLK is low whenever chip select falls, so the level tells the events apart
    always @(posedge spi_sclk or negedge spi_cs_n) begin
        if (!spi_sclk) begin
            frame_idx = frame_idx + 1;
            bit_cnt   = 0;
            byte_pos  = 0;
            if (gap_cycles < MIN_GAP_CYCLES) begin
                $display("error at %0d ns: frame %0d began %0d clk cycles after chip %s",
                         $time, frame_idx, gap_cycles, "select rose, too soon");
                gap_q = gap_q + 1;
            end
        end else if (!spi_cs_n) begin
            shift   = {shift[6:0], spi_miso};   // MSB arrives first
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                want = (byte_pos == 0) ? expected_q : 8'h00;
                if (shift !== want) begin
                    $display("mismatch at %0d ns: spi_miso frame %0d byte %0d expected %02h got %02h",
                             $time, frame_idx, byte_pos, want, shift);
                    mismatch_q = mismatch_q + 1;
                end
                bytes_q  = bytes_q + 1;
                byte_pos = byte_pos + 1;
                bit_cnt  = 0;
            end
        end
    end

endmodule

// File: dv/spi_bridge_tb.sv
// Testbench for the SPI register bridge.
// Frames come from dv/spi_bridge_input.txt and are bit-banged as an SPI
// mode 0 host, 16 ns per bit with a 16-cycle chip-select gap. Inputs
// change 1 ns after a rising clk edge. The checker compares MISO, this
// module counts bytes, watches the cycle limit and prints the verdict.

`timescale 1ns/1ps

module spi_bridge_tb;

    localparam int RESET_CYCLES = 10;
    localparam int GAP_CYCLES   = 16;           // Chip select high between frames
    localparam int HALF_BIT     = 2;            // clk cycles per SCLK phase
    localparam int COLS         = 5;            // Flag, opcode, address, data, reply
    localparam int MAX_FRAMES   = 64;
    localparam int FRAME_BUDGET = 120;          // clk cycles per frame in the limit
    localparam logic [7:0] END_MARK   = 8'hFF;
    localparam logic [7:0] FLAG_PLAIN = 8'h00;
    localparam logic [7:0] FLAG_ABORT = 8'h01;  // Chip select rises after address
    localparam logic [7:0] FLAG_RESET = 8'h02;  // Reset pulse before the frame

    logic       clk;
    logic       reset;
    logic       spi_cs_n;
    logic       spi_sclk;
    logic       spi_mosi;
    logic       spi_miso;
    logic       frame_strobe;
    logic [7:0] exp_reply;

    logic [7:0] stim [MAX_FRAMES*COLS];         // Input file, COLS bytes per frame
    int         frame_count;
    int         expected_bytes = 0;
    int         other_errors   = 0;
    int         cycle_limit    = 0;             // Zero until the file is read
    int         cycle_count    = 0;
    int         mismatch_count;
    int         gap_errors;
    int         bytes_checked;

    spi_bridge_top #(
        .FIFO_DEPTH (4),
        .BANK_WORDS (64)
    ) dut (
        .clk      (clk),
        .reset    (reset),
        .spi_cs_n (spi_cs_n),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    spi_bridge_checker #(
        .MIN_GAP_CYCLES (GAP_CYCLES)
    ) u_checker (
        .clk            (clk),
        .spi_cs_n       (spi_cs_n),
        .spi_sclk       (spi_sclk),
        .spi_miso       (spi_miso),
        .frame_strobe   (frame_strobe),
        .exp_reply      (exp_reply),
        .mismatch_count (mismatch_count),
        .gap_errors     (gap_errors),
        .bytes_checked  (bytes_checked)
    );

    always #2 clk = ~clk;                       // 4 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run still busy after %0d clk cycles", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    // Wait n rising edges, then step 1 ns past the last one
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = value[i];                // Set up while SCLK is low
            wait_cycles(HALF_BIT);
            spi_sclk = 1'b1;
            wait_cycles(HALF_BIT);
            spi_sclk = 1'b0;
        end
    endtask

    task automatic run_frame(input int f);
        logic [7:0] flag;
        logic [7:0] opcode;
        logic [7:0] addr;
        logic [7:0] data;
        logic [7:0] reply;
        flag   = stim[f*COLS];
        opcode = stim[f*COLS+1];
        addr   = stim[f*COLS+2];
        data   = stim[f*COLS+3];
        reply  = stim[f*COLS+4];
        if (flag != FLAG_PLAIN && flag != FLAG_ABORT && flag != FLAG_RESET) begin
            $display("error: frame %0d of the input file has unknown flag %02h", f + 1, flag);
            other_errors++;
        end else begin
            if (flag == FLAG_RESET) begin
                wait_cycles(GAP_CYCLES);        // Let the previous frame finish
                reset = 1'b1;
                wait_cycles(RESET_CYCLES);
                reset = 1'b0;
            end
            wait_cycles(GAP_CYCLES - 1);
            exp_reply    = reply;
            frame_strobe = 1'b1;
            wait_cycles(1);
            frame_strobe = 1'b0;
            spi_cs_n     = 1'b0;
            send_byte(opcode);
            send_byte(addr);
            if (flag != FLAG_ABORT) begin
                send_byte(data);
            end
            wait_cycles(HALF_BIT);
            spi_cs_n = 1'b1;
            expected_bytes += (flag == FLAG_ABORT) ? 2 : 3;
        end
    endtask

    // Frames before the end marker, or -1 when it is missing
    function automatic int count_frames();
        for (int f = 0; f < MAX_FRAMES; f++) begin
            if (stim[f*COLS] == END_MARK) begin
                return f;
            end
        end
        return -1;
    endfunction

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        spi_cs_n     = 1'b1;
        spi_sclk     = 1'b0;
        spi_mosi     = 1'b0;
        frame_strobe = 1'b0;
        exp_reply    = 8'h00;
        $readmemh("dv/spi_bridge_input.txt", stim);
        frame_count = count_frames();
        if (frame_count < 0) begin
            $display("error: input file has no end marker within %0d frames", MAX_FRAMES);
            other_errors++;
            frame_count = 0;
        end
        cycle_limit = 2 * frame_count * FRAME_BUDGET;
        wait_cycles(RESET_CYCLES);
        reset = 1'b0;
        for (int f = 0; f < frame_count; f++) begin
            run_frame(f);
        end
        wait_cycles(GAP_CYCLES);
        if (bytes_checked != expected_bytes) begin
            $display("error: checker saw %0d bytes on MISO but %0d were sent",
                     bytes_checked, expected_bytes);
            other_errors++;
        end
        $display("error counts: %0d mismatches, %0d gap violations, %0d other",
                 mismatch_count, gap_errors, other_errors);
        if (mismatch_count + gap_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: pet_spi.f
src/spi_bridge_pkg.sv
src/spi_byte.sv
src/spi_frame_parser.sv
src/cmd_fifo.sv
src/reg_bank_exec.sv
src/spi_bridge_top.sv
dv/spi_bridge_checker.sv
dv/spi_bridge_tb.sv

// File: Makefile
# Verilator flow for the SPI register bridge
TOP := spi_bridge_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f pet_spi.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f pet_spi.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/spi_bridge_input.txt
// Columns in hex: flag opcode address data reply (reply is the opcode-phase MISO byte)
// Flag 00 plain frame, 01 chip select rises after the address, 02 reset before the frame
00 00 05 3C 00
00 00 12 A5 00
00 01 05 00 00
00 01 12 00 3C
00 01 2A 00 A5
00 01 40 00 00
00 00 40 77 FF
00 01 00 00 FF
00 01 C5 00 00
00 81 3F 00 FF
00 A4 3F 5A 00
00 01 3F 11 00
01 00 05 99 5A
00 01 05 00 5A
01 01 12 00 3C
00 00 07 E1 3C
00 01 07 00 3C
00 00 07 1E E1
00 01 07 00 E1
02 01 05 00 00
00 01 07 00 00
00 00 10 C3 00
00 01 10 00 00
00 01 3F 00 C3
00 00 00 00 00
FF 00 00 00 00
